/* bench/tb_npu_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_npu_ctrl_top
   import npu_ctrl_pkg::*;
();

   localparam int RESULT_WAIT = 64;
   localparam int FC1_LEN     = FC1_ROWS * FC1_COLS * FC1_IN_CH;
   localparam int NUM_RUNS    = 5;

   logic                 npu_clk;
   logic                 npu_rst_n;
   logic                 cfg_write_row_p;
   logic [ROW_CNT_W-1:0] cfg_thrshld_num_rows_to_start;
   logic                 softmax_result_valid_p;
   logic [CLASS_W-1:0]   softmax_class_predicted;
   logic [NUM_BANKS-1:0] mac_overflow;
   logic [NUM_BANKS-1:0] act_overflow;
   logic                 npu_active;
   logic                 npu_done;
   npu_layer_e           npu_layer_in_progress;
   logic [ROW_CNT_W-1:0] img_num_rows_written;
   logic [CLASS_W-1:0]   npu_class_predicted;
   act_rd_t              act_rd;
   filt_rd_t             filt_rd;
   mac_ctl_t             mac_ctl;
   logic                 mac_overflow_lat;
   logic                 act_overflow_lat;

   // Per-layer address table, indexed by layer code
   logic [ACT_ADDR_W-1:0]  offset_tbl [8] = '{13'h0, 13'h0, 13'h0, 13'h0,
                                              13'h1800, 13'h1800, 13'h1A00, 13'h0};
   logic [FILT_ADDR_W-1:0] fstart_tbl [8] = '{11'h0, 11'h0, 11'h0, 11'h0,
                                              11'h000, 11'h180, 11'h300, 11'h0};
   logic [FILT_ADDR_W-1:0] fend_tbl   [8] = '{11'h0, 11'h0, 11'h0, 11'h0,
                                              11'h17F, 11'h2FF, 11'h33F, 11'h0};
   logic [NUM_BANKS-1:0]   mask_tbl   [8] = '{32'h0, 32'h0, 32'h0, 32'h0,
                                              32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h3FF, 32'h0};

   // Image runs: threshold, rows, class, overflow {act, mac}, expected start
   int           run_thr    [NUM_RUNS] = '{0, 5, 4, 1, 0};
   int           run_rows   [NUM_RUNS] = '{3, 2, 4, 1, 2};
   logic [4:0]   run_class  [NUM_RUNS] = '{5'h00, 5'h0B, 5'h13, 5'h1E, 5'h00};
   logic [1:0]   run_ovf    [NUM_RUNS] = '{2'd0, 2'd1, 2'd0, 2'd2, 2'd0};
   bit           run_starts [NUM_RUNS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0};

   // Expected walker steps for one image
   logic [2:0]            exp_code  [$];
   logic [ACT_ADDR_W-1:0] exp_rel   [$];
   bit                    exp_first [$];
   bit                    exp_last  [$];

   // Observed streams
   logic [ACT_ADDR_W-1:0]  act_q     [$];
   int                     act_cyc_q [$];
   logic [NUM_BANKS-1:0]   bank_q    [$];
   mac_ctl_t               mac_q     [$];
   logic [FILT_ADDR_W-1:0] faddr_q   [$];
   int layer_cyc [8];
   int first_act_cyc;
   int first_bank_cyc;
   int first_mac_cyc;

   int     cyc;
   int     last_strobe_cyc;
   int     exp_rows;
   bit     was_done;
   bit     timed_out;
   int     mismatch_cnt;
   int     failure_cnt;
   integer seed = 86;

   npu_ctrl_top #(
      .RESULT_WAIT(RESULT_WAIT)
   ) npu_ctrl_top_inst (
      .npu_clk                       (npu_clk),
      .npu_rst_n                     (npu_rst_n),
      .cfg_write_row_p               (cfg_write_row_p),
      .cfg_thrshld_num_rows_to_start (cfg_thrshld_num_rows_to_start),
      .softmax_result_valid_p        (softmax_result_valid_p),
      .softmax_class_predicted       (softmax_class_predicted),
      .mac_overflow                  (mac_overflow),
      .act_overflow                  (act_overflow),
      .npu_active                    (npu_active),
      .npu_done                      (npu_done),
      .npu_layer_in_progress         (npu_layer_in_progress),
      .img_num_rows_written          (img_num_rows_written),
      .npu_class_predicted           (npu_class_predicted),
      .act_rd                        (act_rd),
      .filt_rd                       (filt_rd),
      .mac_ctl                       (mac_ctl),
      .mac_overflow_lat              (mac_overflow_lat),
      .act_overflow_lat              (act_overflow_lat)
   );

   initial begin
      npu_clk = 1'b0;
      forever #20 npu_clk = ~npu_clk;
   end

   always @(posedge npu_clk) cyc <= cyc + 1;

   //////////////////////////////////////////////////
   // Output monitor, sampled mid cycle
   //////////////////////////////////////////////////
   always @(negedge npu_clk) begin
      if (act_rd.en) begin
         if (first_act_cyc < 0) first_act_cyc = cyc;
         act_q.push_back(act_rd.addr);
         act_cyc_q.push_back(cyc);
      end
      if (filt_rd.bank_en != '0) begin
         if (first_bank_cyc < 0) first_bank_cyc = cyc;
         bank_q.push_back(filt_rd.bank_en);
      end
      if (mac_ctl.en != '0) begin
         if (first_mac_cyc < 0) first_mac_cyc = cyc;
         mac_q.push_back(mac_ctl);
         faddr_q.push_back(filt_rd.addr);
      end
      layer_cyc[npu_layer_in_progress]++;
   end

   task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
      $display("Error %s at %0t: got 0x%h, expected 0x%h", name, $time, got, exp);
      mismatch_cnt++;
   endtask

   task automatic report_failure(string msg);
      $display("Failure at %0t: %s", $time, msg);
      failure_cnt++;
   endtask

   // Row fastest, then column, then channel
   function automatic logic [ACT_ADDR_W-1:0] flat_addr(int k);
      int row;
      int col;
      int ch;
      row = k % FC1_ROWS;
      col = (k / FC1_ROWS) % FC1_COLS;
      ch  = k / (FC1_ROWS * FC1_COLS);
      return ACT_ADDR_W'(ch * FC1_ROWS * FC1_COLS + row * FC1_COLS + col);
   endfunction

   task automatic push_step(logic [2:0] code, logic [ACT_ADDR_W-1:0] rel, bit first, bit last);
      exp_code.push_back(code);
      exp_rel.push_back(rel);
      exp_first.push_back(first);
      exp_last.push_back(last);
   endtask

   task automatic build_steps();
      logic [2:0] code;
      for (int p = 0; p < 2; p++) begin
         code = (p == 0) ? LAYER_FC1_1 : LAYER_FC1_2;
         for (int k = 0; k < FC1_LEN; k++) begin
            push_step(code, flat_addr(k), k == 0, k == FC1_LEN - 1);
         end
      end
      for (int j = 0; j < FC2_LEN; j++) begin
         push_step(LAYER_FC2, ACT_ADDR_W'(j), j == 0, j == FC2_LEN - 1);
      end
   endtask

   task automatic compare_streams();
      int                     n;
      int                     gap;
      int                     exp_len;
      int                     cnt [8];
      logic [2:0]             code;
      logic [FILT_ADDR_W-1:0] fa;
      logic [ACT_ADDR_W-1:0]  exp_addr;
      n   = exp_code.size();
      gap = 0;
      foreach (cnt[c]) cnt[c] = 0;
      if (act_q.size() != n) report_failure($sformatf("%0d act reads, expected %0d",
                                                      act_q.size(), n));
      if (mac_q.size() != n) report_failure($sformatf("%0d MAC enables, expected %0d",
                                                      mac_q.size(), n));
      if (bank_q.size() != n) report_failure("bank enable count differs from step count");
      for (int i = 0; i < n; i++) begin
         code     = exp_code[i];
         exp_addr = exp_rel[i] + offset_tbl[code];
         // A result-write wait sits between consecutive layers
         if (i > 0 && code != exp_code[i-1]) gap = gap + RESULT_WAIT;
         fa = fstart_tbl[code] +
              FILT_ADDR_W'(cnt[code] % (fend_tbl[code] - fstart_tbl[code] + 1));
         cnt[code]++;
         if (i < act_q.size()) begin
            if (act_q[i] !== exp_addr)
               report_mismatch("act_rd.addr", 32'(act_q[i]), 32'(exp_addr));
            if (act_cyc_q[i] != first_act_cyc + i + gap)
               report_failure($sformatf("act read %0d came in cycle %0d, expected %0d",
                                        i, act_cyc_q[i], first_act_cyc + i + gap));
         end
         if (i < bank_q.size() && bank_q[i] !== mask_tbl[code])
            report_mismatch("filt_rd.bank_en", bank_q[i], mask_tbl[code]);
         if (i < mac_q.size()) begin
            if (mac_q[i].en !== mask_tbl[code])
               report_mismatch("mac_ctl.en", mac_q[i].en, mask_tbl[code]);
            if (mac_q[i].start !== exp_first[i])
               report_mismatch("mac_ctl.start", 32'(mac_q[i].start), 32'(exp_first[i]));
            if (mac_q[i].last !== exp_last[i])
               report_mismatch("mac_ctl.last", 32'(mac_q[i].last), 32'(exp_last[i]));
            if (faddr_q[i] !== fa) report_mismatch("filt_rd.addr", 32'(faddr_q[i]), 32'(fa));
         end
      end
      // FC1 codes also cover the wait that follows them
      for (int c = 4; c <= 6; c++) begin
         exp_len = cnt[c] + ((c == LAYER_FC2) ? 0 : RESULT_WAIT);
         if (layer_cyc[c] != exp_len)
            report_failure($sformatf("layer %0d lasted %0d cycles, expected %0d",
                                     c, layer_cyc[c], exp_len));
      end
      if (first_act_cyc - last_strobe_cyc != 5) report_failure("wrong start latency");
      if (first_bank_cyc != first_act_cyc + 1) report_failure("bank enable misaligned");
      if (first_mac_cyc != first_act_cyc + 2) report_failure("MAC enable misaligned");
   endtask

   task automatic wait_for_layer(npu_layer_e code, int limit);
      int n;
      n = 0;
      while (npu_layer_in_progress !== code && n < limit) begin
         @(negedge npu_clk);
         n++;
      end
      if (npu_layer_in_progress !== code) begin
         report_failure("timeout, layer code never reached");
         timed_out = 1'b1;
      end
   endtask

   task automatic write_row();
      int gap;
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(negedge npu_clk);
      if (was_done && npu_done !== 1'b1) report_mismatch("npu_done", 32'(npu_done), 32'h1);
      if (npu_active !== 1'b0 || act_rd.en !== 1'b0)
         report_failure("activity before the row threshold was met");
      cfg_write_row_p = 1'b1;
      last_strobe_cyc = cyc;
      exp_rows        = exp_rows + 1;
      @(negedge npu_clk);
      cfg_write_row_p = 1'b0;
      if (img_num_rows_written !== ROW_CNT_W'(exp_rows))
         report_mismatch("img_num_rows_written", 32'(img_num_rows_written), 32'(exp_rows));
      if (was_done) begin
         if (npu_layer_in_progress !== LAYER_IDLE)
            report_mismatch("npu_layer_in_progress", 32'(npu_layer_in_progress), 32'h0);
         if (npu_done !== 1'b0) report_mismatch("npu_done", 32'(npu_done), 32'h0);
         @(negedge npu_clk);
         if (mac_overflow_lat !== 1'b0)
            report_mismatch("mac_overflow_lat", 32'(mac_overflow_lat), 32'h0);
         if (act_overflow_lat !== 1'b0)
            report_mismatch("act_overflow_lat", 32'(act_overflow_lat), 32'h0);
         was_done = 1'b0;
      end
   endtask

   task automatic run_image(int r);
      logic [1:0] ovf;
      ovf = run_ovf[r];
      act_q.delete();
      act_cyc_q.delete();
      bank_q.delete();
      mac_q.delete();
      faddr_q.delete();
      foreach (layer_cyc[c]) layer_cyc[c] = 0;
      first_act_cyc  = -1;
      first_bank_cyc = -1;
      first_mac_cyc  = -1;
      cfg_thrshld_num_rows_to_start = ROW_CNT_W'(run_thr[r]);
      for (int k = 0; k < run_rows[r]; k++) write_row();
      if (!run_starts[r]) begin
         repeat (20) begin
            @(negedge npu_clk);
            if (npu_active !== 1'b0) report_failure("NPU started below its threshold");
         end
         if (act_q.size() != 0) report_failure("act read issued while idle");
      end else begin
         if (ovf != 2'd0) begin
            repeat (10) @(negedge npu_clk);
            mac_overflow = ovf[0] ? 32'h0000_0100 : 32'h0;
            act_overflow = ovf[1] ? 32'h8000_0000 : 32'h0;
            @(negedge npu_clk);
            mac_overflow = '0;
            act_overflow = '0;
         end
         wait_for_layer(LAYER_SOFTMAX, 3000);
         if (timed_out) return;
         // Let the five stage pipeline drain
         repeat (8) @(negedge npu_clk);
         compare_streams();
         if (mac_overflow_lat !== ovf[0])
            report_mismatch("mac_overflow_lat", 32'(mac_overflow_lat), 32'(ovf[0]));
         if (act_overflow_lat !== ovf[1])
            report_mismatch("act_overflow_lat", 32'(act_overflow_lat), 32'(ovf[1]));
         softmax_class_predicted = run_class[r];
         softmax_result_valid_p  = 1'b1;
         @(negedge npu_clk);
         softmax_result_valid_p = 1'b0;
         if (npu_done !== 1'b1) report_mismatch("npu_done", 32'(npu_done), 32'h1);
         if (npu_active !== 1'b0) report_mismatch("npu_active", 32'(npu_active), 32'h0);
         if (npu_class_predicted !== run_class[r])
            report_mismatch("npu_class_predicted", 32'(npu_class_predicted), 32'(run_class[r]));
         @(negedge npu_clk);
         exp_rows = 0;
         was_done = 1'b1;
         if (img_num_rows_written !== 6'd0)
            report_mismatch("img_num_rows_written", 32'(img_num_rows_written), 32'h0);
      end
   endtask

   initial begin
      npu_rst_n                     = 1'b0;
      cfg_write_row_p               = 1'b0;
      cfg_thrshld_num_rows_to_start = '0;
      softmax_result_valid_p        = 1'b0;
      softmax_class_predicted       = '0;
      mac_overflow                  = '0;
      act_overflow                  = '0;
      exp_rows                      = 0;
      was_done                      = 1'b0;
      timed_out                     = 1'b0;
      mismatch_cnt                  = 0;
      failure_cnt                   = 0;
      repeat (10) @(negedge npu_clk);
      npu_rst_n = 1'b1;
      @(negedge npu_clk);
      if (npu_active !== 1'b0 || npu_done !== 1'b0 || act_rd.en !== 1'b0 ||
          mac_ctl.en !== '0 || mac_overflow_lat !== 1'b0 || act_overflow_lat !== 1'b0 ||
          npu_layer_in_progress !== LAYER_IDLE || img_num_rows_written !== '0)
         report_failure("outputs not cleared after reset");
      build_steps();
      for (int r = 0; r < NUM_RUNS && !timed_out; r++) run_image(r);
      $display("mismatches=%0d other_failures=%0d", mismatch_cnt, failure_cnt);
      if (mismatch_cnt == 0 && failure_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* common/npu_ctrl_pkg.sv */
`default_nettype none

package npu_ctrl_pkg;

   //////////////////////////////////////////////////
   // Widths and FC geometry
   //////////////////////////////////////////////////
   localparam int ACT_ADDR_W  = 13;
   localparam int FILT_ADDR_W = 11;
   localparam int NUM_BANKS   = 32;
   localparam int ROW_CNT_W   = 6;
   localparam int CLASS_W     = 5;

   // FC1 input volume, flattened row first
   localparam int FC1_ROWS    = 4;
   localparam int FC1_COLS    = 4;
   localparam int FC1_IN_CH   = 24;
   localparam int FC2_LEN     = 64;

   // Value seen on npu_layer_in_progress
   typedef enum logic [2:0] {
      LAYER_IDLE    = 3'd0,
      LAYER_FC1_1   = 3'd4,
      LAYER_FC1_2   = 3'd5,
      LAYER_FC2     = 3'd6,
      LAYER_SOFTMAX = 3'd7
   } npu_layer_e;

   //////////////////////////////////////////////////
   // Pipeline payloads
   //////////////////////////////////////////////////
   typedef struct packed {
      logic                  valid;
      npu_layer_e            layer;
      logic [ACT_ADDR_W-1:0] addr;
      logic                  first;
      logic                  last;
   } fc_step_t;

   typedef struct packed {
      logic                  en;
      logic [ACT_ADDR_W-1:0] addr;
   } act_rd_t;

   typedef struct packed {
      logic [NUM_BANKS-1:0]   bank_en;
      logic [FILT_ADDR_W-1:0] addr;
   } filt_rd_t;

   typedef struct packed {
      logic [NUM_BANKS-1:0] en;
      logic                 start;
      logic                 last;
   } mac_ctl_t;

   typedef struct packed {
      logic [ACT_ADDR_W-1:0]  act_offset;
      logic [FILT_ADDR_W-1:0] filt_start;
      logic [FILT_ADDR_W-1:0] filt_end;
      logic [NUM_BANKS-1:0]   bank_mask;
   } layer_cfg_t;

   // Indexed by layer code, unused codes read as zero
   localparam layer_cfg_t LAYER_CFG [8] = '{
      LAYER_FC1_1: '{act_offset: 13'h1800, filt_start: 11'h000, filt_end: 11'h17F,
                     bank_mask: 32'hFFFF_FFFF},
      LAYER_FC1_2: '{act_offset: 13'h1800, filt_start: 11'h180, filt_end: 11'h2FF,
                     bank_mask: 32'hFFFF_FFFF},
      LAYER_FC2:   '{act_offset: 13'h1A00, filt_start: 11'h300, filt_end: 11'h33F,
                     bank_mask: 32'h0000_03FF},
      default:     '0
   };

endpackage

`default_nettype wire

/* fc_walk/npu_ctrl_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module npu_ctrl_delay #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 1
) (
   input  wire logic     npu_clk,
   input  wire logic     npu_rst_n,
   input  wire payload_t din,
   output payload_t      dout
);

   payload_t pipe [DEPTH];

   // Plain shift chain, stage 0 takes the input
   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         for (int i = 0; i < DEPTH; i++) begin
            pipe[i] <= '0;
         end
      end else begin
         pipe[0] <= din;
         for (int i = 1; i < DEPTH; i++) begin
            pipe[i] <= pipe[i-1];
         end
      end
   end

   assign dout = pipe[DEPTH-1];

endmodule

`default_nettype wire

/* fc_walk/npu_fc_act_walker.sv */
`timescale 1ns/1ps
`default_nettype none

module npu_fc_act_walker
   import npu_ctrl_pkg::*;
(
   input  wire logic       npu_clk,
   input  wire logic       npu_rst_n,
   input  wire npu_layer_e layer,
   output fc_step_t        step
);

   localparam int ROW_W = $clog2(FC1_ROWS);
   localparam int COL_W = $clog2(FC1_COLS);
   localparam int CH_W  = $clog2(FC1_IN_CH);
   localparam int F2_W  = $clog2(FC2_LEN);

   logic [ROW_W-1:0]      row_cnt;
   logic [COL_W-1:0]      col_cnt;
   logic [CH_W-1:0]       ch_cnt;
   logic [F2_W-1:0]       fc2_cnt;
   logic                  in_fc1;
   logic                  in_fc2;
   logic                  row_max;
   logic                  col_max;
   logic                  ch_max;
   logic [ACT_ADDR_W-1:0] fc1_addr;
   logic                  active;
   npu_layer_e            fin_layer;

   assign in_fc1  = (layer == LAYER_FC1_1) || (layer == LAYER_FC1_2);
   assign in_fc2  = (layer == LAYER_FC2);
   assign row_max = (row_cnt == ROW_W'(FC1_ROWS - 1));
   assign col_max = (col_cnt == COL_W'(FC1_COLS - 1));
   assign ch_max  = (ch_cnt == CH_W'(FC1_IN_CH - 1));

   // A wait state keeps the code of the layer just walked, so that layer stays quiet
   assign active  = (in_fc1 || in_fc2) && (layer != fin_layer);

   // Flatten order is row, then column, then channel
   assign fc1_addr = ACT_ADDR_W'(ch_cnt) * ACT_ADDR_W'(FC1_ROWS * FC1_COLS)
                   + ACT_ADDR_W'(row_cnt) * ACT_ADDR_W'(FC1_COLS)
                   + ACT_ADDR_W'(col_cnt);

   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         row_cnt   <= '0;
         col_cnt   <= '0;
         ch_cnt    <= '0;
         fc2_cnt   <= '0;
         fin_layer <= LAYER_IDLE;
      end else begin
         if (!in_fc1) begin
            row_cnt <= '0;
            col_cnt <= '0;
            ch_cnt  <= '0;
         end else if (active) begin
            row_cnt <= row_max ? '0 : row_cnt + ROW_W'(1);
            if (row_max) col_cnt <= col_max ? '0 : col_cnt + COL_W'(1);
            if (row_max && col_max) ch_cnt <= ch_max ? '0 : ch_cnt + CH_W'(1);
         end
         // FC2 reads linearly and parks on the last element
         if (!in_fc2) fc2_cnt <= '0;
         else if (active && fc2_cnt != F2_W'(FC2_LEN - 1)) fc2_cnt <= fc2_cnt + F2_W'(1);
         // Layer whose last step went out, kept until the NPU idles
         if (layer == LAYER_IDLE) fin_layer <= LAYER_IDLE;
         else if (step.valid && step.last) fin_layer <= layer;
      end
   end

   always_comb begin
      step       = '0;
      step.layer = layer;
      if (active && in_fc1) begin
         step.valid = 1'b1;
         step.addr  = fc1_addr;
         step.first = (row_cnt == '0) && (col_cnt == '0) && (ch_cnt == '0);
         step.last  = row_max && col_max && ch_max;
      end else if (active && in_fc2) begin
         step.valid = 1'b1;
         step.addr  = ACT_ADDR_W'(fc2_cnt);
         step.first = (fc2_cnt == '0);
         step.last  = (fc2_cnt == F2_W'(FC2_LEN - 1));
      end
   end

endmodule

`default_nettype wire

/* npu_ctrl_top.f */
common/npu_ctrl_pkg.sv
fc_walk/npu_ctrl_delay.sv
fc_walk/npu_fc_act_walker.sv
sequencer/npu_layer_fsm.sv
sequencer/npu_status_regs.sv
rtl/npu_mem_rd_gen.sv
rtl/npu_ctrl_top.sv
bench/tb_npu_ctrl_top.sv

/* rtl/npu_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module npu_ctrl_top
   import npu_ctrl_pkg::*;
#(
   parameter int RESULT_WAIT = 64
) (
   input  wire logic                 npu_clk,
   input  wire logic                 npu_rst_n,
   // CPU image write side
   input  wire logic                 cfg_write_row_p,
   input  wire logic [ROW_CNT_W-1:0] cfg_thrshld_num_rows_to_start,
   // Softmax unit
   input  wire logic                 softmax_result_valid_p,
   input  wire logic [CLASS_W-1:0]   softmax_class_predicted,
   // MAC array status
   input  wire logic [NUM_BANKS-1:0] mac_overflow,
   input  wire logic [NUM_BANKS-1:0] act_overflow,
   // Status
   output logic                      npu_active,
   output logic                      npu_done,
   output npu_layer_e                npu_layer_in_progress,
   output logic [ROW_CNT_W-1:0]      img_num_rows_written,
   output logic [CLASS_W-1:0]        npu_class_predicted,
   // Memory and MAC control
   output act_rd_t                   act_rd,
   output filt_rd_t                  filt_rd,
   output mac_ctl_t                  mac_ctl,
   output logic                      mac_overflow_lat,
   output logic                      act_overflow_lat
);

   fc_step_t step;

   npu_layer_fsm #(
      .RESULT_WAIT(RESULT_WAIT)
   ) npu_layer_fsm_inst (
      .npu_clk                       (npu_clk),
      .npu_rst_n                     (npu_rst_n),
      .cfg_write_row_p               (cfg_write_row_p),
      .cfg_thrshld_num_rows_to_start (cfg_thrshld_num_rows_to_start),
      .softmax_result_valid_p        (softmax_result_valid_p),
      .step                          (step),
      .layer                         (npu_layer_in_progress),
      .npu_active                    (npu_active),
      .npu_done                      (npu_done),
      .img_num_rows_written          (img_num_rows_written)
   );

   npu_status_regs npu_status_regs_inst (
      .npu_clk                 (npu_clk),
      .npu_rst_n               (npu_rst_n),
      .layer                   (npu_layer_in_progress),
      .softmax_result_valid_p  (softmax_result_valid_p),
      .softmax_class_predicted (softmax_class_predicted),
      .mac_overflow            (mac_overflow),
      .act_overflow            (act_overflow),
      .npu_class_predicted     (npu_class_predicted),
      .mac_overflow_lat        (mac_overflow_lat),
      .act_overflow_lat        (act_overflow_lat)
   );

   npu_fc_act_walker npu_fc_act_walker_inst (
      .npu_clk   (npu_clk),
      .npu_rst_n (npu_rst_n),
      .layer     (npu_layer_in_progress),
      .step      (step)
   );

   npu_mem_rd_gen npu_mem_rd_gen_inst (
      .npu_clk   (npu_clk),
      .npu_rst_n (npu_rst_n),
      .step      (step),
      .act_rd    (act_rd),
      .filt_rd   (filt_rd),
      .mac_ctl   (mac_ctl)
   );

endmodule

`default_nettype wire

/* rtl/npu_mem_rd_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module npu_mem_rd_gen
   import npu_ctrl_pkg::*;
(
   input  wire logic     npu_clk,
   input  wire logic     npu_rst_n,
   input  wire fc_step_t step,
   output act_rd_t       act_rd,
   output filt_rd_t      filt_rd,
   output mac_ctl_t      mac_ctl
);

   fc_step_t   step_d2;
   fc_step_t   s3;
   fc_step_t   s4;
   layer_cfg_t cfg2;
   layer_cfg_t cfg3;
   layer_cfg_t cfg4;
   mac_ctl_t   mac_nxt;

   npu_ctrl_delay #(
      .payload_t(fc_step_t),
      .DEPTH    (2)
   ) step_dly_inst (
      .npu_clk   (npu_clk),
      .npu_rst_n (npu_rst_n),
      .din       (step),
      .dout      (step_d2)
   );

   assign cfg2 = LAYER_CFG[step_d2.layer];
   assign cfg3 = LAYER_CFG[s3.layer];
   assign cfg4 = LAYER_CFG[s4.layer];

   //////////////////////////////////////////////////
   // Stage 3 act read, stage 4 banks, stage 5 filter addr
   //////////////////////////////////////////////////
   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         act_rd  <= '0;
         filt_rd <= '0;
         s3      <= '0;
         s4      <= '0;
      end else begin
         act_rd.en      <= step_d2.valid;
         act_rd.addr    <= step_d2.addr + cfg2.act_offset;
         s3             <= step_d2;
         s4             <= s3;
         filt_rd.bank_en <= s3.valid ? cfg3.bank_mask : '0;
         // Filter addr walks the layer window and wraps at its end
         if (s4.valid) begin
            if (s4.first || (filt_rd.addr == cfg4.filt_end)) begin
               filt_rd.addr <= cfg4.filt_start;
            end else begin
               filt_rd.addr <= filt_rd.addr + FILT_ADDR_W'(1);
            end
         end
      end
   end

   always_comb begin
      mac_nxt = '0;
      if (s4.valid) begin
         mac_nxt.en    = cfg4.bank_mask;
         mac_nxt.start = s4.first;
         mac_nxt.last  = s4.last;
      end
   end

   // MAC strobes line up with the filter addr
   npu_ctrl_delay #(
      .payload_t(mac_ctl_t),
      .DEPTH    (1)
   ) mac_dly_inst (
      .npu_clk   (npu_clk),
      .npu_rst_n (npu_rst_n),
      .din       (mac_nxt),
      .dout      (mac_ctl)
   );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_npu_ctrl_top -f npu_ctrl_top.f || exit 1
out="$(./obj_dir/Vtb_npu_ctrl_top)"
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

/* sequencer/npu_layer_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module npu_layer_fsm
   import npu_ctrl_pkg::*;
#(
   parameter int RESULT_WAIT = 64
) (
   input  wire logic                 npu_clk,
   input  wire logic                 npu_rst_n,
   input  wire logic                 cfg_write_row_p,
   input  wire logic [ROW_CNT_W-1:0] cfg_thrshld_num_rows_to_start,
   input  wire logic                 softmax_result_valid_p,
   input  wire fc_step_t             step,
   output npu_layer_e                layer,
   output logic                      npu_active,
   output logic                      npu_done,
   output logic [ROW_CNT_W-1:0]      img_num_rows_written
);

   localparam int WAIT_W = $clog2(RESULT_WAIT + 1);

   typedef enum logic [2:0] {
      S_IDLE, S_FC1_1, S_WAIT1, S_FC1_2, S_WAIT2, S_FC2, S_SOFTMAX, S_DONE
   } state_e;

   state_e              state_q;
   state_e              state_d;
   logic [WAIT_W-1:0]   wait_cnt;
   logic                done_q;
   logic                in_wait;
   logic                wait_done;
   logic                trigger;
   logic                layer_end;

   assign trigger    = (img_num_rows_written >= cfg_thrshld_num_rows_to_start) &&
                       (|cfg_thrshld_num_rows_to_start);
   assign in_wait    = (state_q == S_WAIT1) || (state_q == S_WAIT2);
   assign wait_done  = in_wait && (wait_cnt == WAIT_W'(RESULT_WAIT - 1));
   // Walker last flag is the only end of layer marker
   assign layer_end  = step.valid && step.last;
   assign npu_done   = (state_q == S_DONE);
   assign npu_active = (state_q != S_IDLE) && (state_q != S_DONE);

   always_comb begin
      state_d = state_q;
      layer   = LAYER_IDLE;
      case (state_q)
         S_IDLE: begin
            if (trigger) state_d = S_FC1_1;
         end
         S_FC1_1: begin
            layer = LAYER_FC1_1;
            if (layer_end) state_d = S_WAIT1;
         end
         S_WAIT1: begin
            layer = LAYER_FC1_1;
            if (wait_done) state_d = S_FC1_2;
         end
         S_FC1_2: begin
            layer = LAYER_FC1_2;
            if (layer_end) state_d = S_WAIT2;
         end
         S_WAIT2: begin
            layer = LAYER_FC1_2;
            if (wait_done) state_d = S_FC2;
         end
         S_FC2: begin
            layer = LAYER_FC2;
            if (layer_end) state_d = S_SOFTMAX;
         end
         S_SOFTMAX: begin
            layer = LAYER_SOFTMAX;
            if (softmax_result_valid_p) state_d = S_DONE;
         end
         default: begin
            // Done holds until the CPU starts the next image
            layer = LAYER_SOFTMAX;
            if (cfg_write_row_p) state_d = S_IDLE;
         end
      endcase
   end

   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         state_q              <= S_IDLE;
         wait_cnt             <= '0;
         done_q               <= 1'b0;
         img_num_rows_written <= '0;
      end else begin
         state_q  <= state_d;
         done_q   <= npu_done;
         wait_cnt <= in_wait ? wait_cnt + WAIT_W'(1) : '0;
         // Row count restarts one cycle into DONE
         if (npu_done && !done_q) begin
            img_num_rows_written <= '0;
         end else if (cfg_write_row_p) begin
            img_num_rows_written <= img_num_rows_written + ROW_CNT_W'(1);
         end
      end
   end

endmodule

`default_nettype wire

/* sequencer/npu_status_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module npu_status_regs
   import npu_ctrl_pkg::*;
(
   input  wire logic                 npu_clk,
   input  wire logic                 npu_rst_n,
   input  wire npu_layer_e           layer,
   input  wire logic                 softmax_result_valid_p,
   input  wire logic [CLASS_W-1:0]   softmax_class_predicted,
   input  wire logic [NUM_BANKS-1:0] mac_overflow,
   input  wire logic [NUM_BANKS-1:0] act_overflow,
   output logic [CLASS_W-1:0]        npu_class_predicted,
   output logic                      mac_overflow_lat,
   output logic                      act_overflow_lat
);

   logic idle;

   assign idle = (layer == LAYER_IDLE);

   always_ff @(posedge npu_clk or negedge npu_rst_n) begin
      if (!npu_rst_n) begin
         npu_class_predicted <= '0;
         mac_overflow_lat    <= 1'b0;
         act_overflow_lat    <= 1'b0;
      end else begin
         if (softmax_result_valid_p) npu_class_predicted <= softmax_class_predicted;
         // Sticky until the NPU goes back to idle
         mac_overflow_lat <= idle ? 1'b0 : (mac_overflow_lat || (|mac_overflow));
         act_overflow_lat <= idle ? 1'b0 : (act_overflow_lat || (|act_overflow));
      end
   end

endmodule

`default_nettype wire
